// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // Line geometry
    localparam int unsigned LINE_BYTES = 16;
    localparam int unsigned LINE_WORDS = LINE_BYTES / 4;
    localparam int unsigned OFFSET_W   = 4;
    localparam int unsigned INDEX_W    = 4;
    localparam int unsigned TAG_W      = 32 - INDEX_W - OFFSET_W;
    localparam int unsigned NUM_LINES  = 1 << INDEX_W;

    localparam logic [31:0] RESET_PC = 32'h3000_0000;

    // Top nibbles of the SDRAM window, filled by burst
    localparam logic [3:0] SDRAM_LO = 4'hA;
    localparam logic [3:0] SDRAM_HI = 4'hB;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_BUSY
    } fetch_state_e;

    typedef enum logic {
        REFILL_SINGLE,
        REFILL_BURST
    } refill_mode_e;

endpackage

// ==== hw/icache_refill_if.sv ====
`timescale 1ns/1ps

interface icache_refill_if;
    import fetch_pkg::*;

    logic [31:0]             lookup_addr;
    logic                    hit;
    logic [31:0]             hit_data;
    // Fault flag of the line that hit
    logic                    hit_fault;
    logic                    fill_req;
    logic [31:0]             fill_addr;
    logic [LINE_BYTES*8-1:0] fill_data;
    logic                    fill_done;
    logic                    fill_fault;

    modport cache (
        input  lookup_addr, fill_data, fill_done, fill_fault,
        output hit, hit_data, hit_fault, fill_req, fill_addr
    );

    modport fetch (
        output lookup_addr, fill_data, fill_done, fill_fault,
        input  hit, hit_data, hit_fault, fill_req, fill_addr
    );

endinterface

// ==== hw/icache.sv ====
`timescale 1ns/1ps

module icache (
    input logic            clk,
    input logic            rst,
    icache_refill_if.cache refill
);
    import fetch_pkg::*;

    // Line storage
    logic [LINE_BYTES*8-1:0] data_mem [0:NUM_LINES-1];
    logic [TAG_W-1:0]        tag_mem  [0:NUM_LINES-1];
    logic [NUM_LINES-1:0]    valid_q;
    logic [NUM_LINES-1:0]    fault_q;

    // Lookup side fields
    logic [INDEX_W-1:0]      lookup_index;
    logic [TAG_W-1:0]        lookup_tag;
    logic [OFFSET_W-3:0]     lookup_word;
    logic [LINE_BYTES*8-1:0] lookup_line;
    logic                    tag_match;

    // Fill side fields
    logic [INDEX_W-1:0]      fill_index;
    logic [TAG_W-1:0]        fill_tag;

    assign lookup_index = refill.lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag   = refill.lookup_addr[31 -: TAG_W];
    assign lookup_word  = refill.lookup_addr[OFFSET_W-1:2];
    assign lookup_line  = data_mem[lookup_index];

    assign tag_match = (tag_mem[lookup_index] == lookup_tag);

    // Zero-cycle lookup
    assign refill.hit       = valid_q[lookup_index] && tag_match;
    assign refill.hit_data  = lookup_line[lookup_word*32 +: 32];
    assign refill.hit_fault = refill.hit && fault_q[lookup_index];

    // Miss request stays up until the line has been written
    assign refill.fill_req  = !refill.hit;
    assign refill.fill_addr = {refill.lookup_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    assign fill_index = refill.fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag   = refill.fill_addr[31 -: TAG_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill.fill_done) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // Line, tag and fault bit land together with the valid bit
    always_ff @(posedge clk) begin
        if (refill.fill_done) begin
            data_mem[fill_index] <= refill.fill_data;
            tag_mem[fill_index]  <= fill_tag;
            fault_q[fill_index]  <= refill.fill_fault;
        end
    end

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/1ps

module ifu (
    input  logic           clk,
    input  logic           rst,
    input  logic           exu_dnpc_valid,
    input  logic [31:0]    exu_dnpc,
    input  logic           idu_ready,
    output logic           ifu_valid,
    output logic [31:0]    ifu_pc,
    output logic [31:0]    ifu_inst,
    output logic           access_fault,

    output logic           arvalid,
    input  logic           arready,
    output logic [31:0]    araddr,
    output logic [3:0]     arid,
    output logic [7:0]     arlen,
    output logic [2:0]     arsize,
    output logic [1:0]     arburst,

    input  logic           rvalid,
    output logic           rready,
    input  logic [31:0]    rdata,
    input  logic [1:0]     rresp,
    input  logic           rlast,
    input  logic [3:0]     rid,

    icache_refill_if.fetch refill
);
    import fetch_pkg::*;

    fetch_state_e state;
    refill_mode_e mode;

    logic [31:0] pc;
    logic        redirect_pending;
    logic [31:0] redirect_target;
    logic        redirect_now;
    logic [31:0] redirect_pc;

    logic        issue;
    logic        pc_update;
    logic        fill_start;
    logic        fill_is_sdram;

    logic        ar_fire;
    logic        r_fire;
    logic        beat_err;
    logic        last_beat;
    logic        next_single;
    logic [1:0]  beat;

    assign arid   = 4'd0;
    assign arsize = 3'd2;

    assign refill.lookup_addr = pc;

    // A pulse in this cycle wins over an older pending target
    assign redirect_now = redirect_pending || exu_dnpc_valid;
    assign redirect_pc  = exu_dnpc_valid ? exu_dnpc : redirect_target;

    assign issue     = (state == FETCH_IDLE) && refill.hit && !redirect_now;
    assign pc_update = (state == FETCH_IDLE) && idu_ready && (refill.hit || redirect_now);

    // Line is written at the end of the fill_done cycle, so no new miss then
    assign fill_start = (state == FETCH_IDLE) && refill.fill_req && !refill.fill_done
                        && !redirect_now;

    assign fill_is_sdram = (refill.fill_addr[31:28] == SDRAM_LO)
                           || (refill.fill_addr[31:28] == SDRAM_HI);

    assign ar_fire     = arvalid && arready;
    assign r_fire      = rvalid && rready;
    assign beat_err    = (rresp != 2'b00) || (rid != arid);
    assign last_beat   = (mode == REFILL_BURST) ? rlast : (beat == 2'(LINE_WORDS - 1));
    assign next_single = r_fire && !last_beat && (mode == REFILL_SINGLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= redirect_now ? redirect_pc : pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_pending <= 1'b0;
        end else if (pc_update) begin
            redirect_pending <= 1'b0;
        end else if (exu_dnpc_valid) begin
            redirect_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (exu_dnpc_valid) begin
            redirect_target <= exu_dnpc;
        end
    end

    // Decode side registers, frozen while decode stalls
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifu_valid    <= 1'b0;
            access_fault <= 1'b0;
        end else if (idu_ready) begin
            ifu_valid    <= issue;
            access_fault <= issue && refill.hit_fault;
        end
    end

    always_ff @(posedge clk) begin
        if (idu_ready && issue) begin
            ifu_pc   <= pc;
            ifu_inst <= refill.hit_data;
        end
    end

    // Refill control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state             <= FETCH_IDLE;
            mode              <= REFILL_SINGLE;
            arvalid           <= 1'b0;
            rready            <= 1'b0;
            beat              <= 2'd0;
            refill.fill_done  <= 1'b0;
            refill.fill_fault <= 1'b0;
        end else begin
            refill.fill_done <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (fill_start) begin
                        state             <= FETCH_BUSY;
                        mode              <= fill_is_sdram ? REFILL_BURST : REFILL_SINGLE;
                        arvalid           <= 1'b1;
                        beat              <= 2'd0;
                        refill.fill_fault <= 1'b0;
                    end
                end
                FETCH_BUSY: begin
                    if (ar_fire) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat <= beat + 2'd1;
                        if (beat_err) begin
                            refill.fill_fault <= 1'b1;
                        end
                        if (last_beat) begin
                            rready           <= 1'b0;
                            refill.fill_done <= 1'b1;
                            state            <= FETCH_IDLE;
                        end else if (mode == REFILL_SINGLE) begin
                            // Next word needs its own AR
                            rready  <= 1'b0;
                            arvalid <= 1'b1;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // AR payload and line gathering
    always_ff @(posedge clk) begin
        if (fill_start) begin
            araddr  <= refill.fill_addr;
            arlen   <= fill_is_sdram ? 8'(LINE_WORDS - 1) : 8'd0;
            arburst <= fill_is_sdram ? 2'b01 : 2'b00;
        end else if (next_single) begin
            araddr <= araddr + 32'd4;
        end
        if (r_fire) begin
            refill.fill_data[beat*32 +: 32] <= rdata;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        exu_dnpc_valid,
    input  logic [31:0] exu_dnpc,
    input  logic        idu_ready,
    output logic        ifu_valid,
    output logic [31:0] ifu_pc,
    output logic [31:0] ifu_inst,
    output logic        access_fault,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,

    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    icache_refill_if refill_bus ();

    ifu ifu_unit (
        .clk            (clk),
        .rst            (rst),
        .exu_dnpc_valid (exu_dnpc_valid),
        .exu_dnpc       (exu_dnpc),
        .idu_ready      (idu_ready),
        .ifu_valid      (ifu_valid),
        .ifu_pc         (ifu_pc),
        .ifu_inst       (ifu_inst),
        .access_fault   (access_fault),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arid           (arid),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rid            (rid),
        .refill         (refill_bus.fetch)
    );

    icache icache_unit (
        .clk    (clk),
        .rst    (rst),
        .refill (refill_bus.cache)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);
    localparam logic [31:0] DATA_KEY    = 32'h5A5A_5A5A;
    localparam logic [1:0]  RESP_OKAY   = 2'b00;
    localparam logic [1:0]  RESP_SLVERR = 2'b10;

    logic [31:0] rnd;
    logic        busy;
    logic [31:0] addr;
    logic [7:0]  beats_left;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign rid = 4'd0;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rnd        <= 32'd27;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rdata      <= '0;
            rresp      <= RESP_OKAY;
            rlast      <= 1'b0;
            busy       <= 1'b0;
            addr       <= '0;
            beats_left <= '0;
            ar_wait    <= 2'd0;
            r_wait     <= 2'd0;
        end else begin
            // Address phase with a random wait before arready
            if (arvalid && arready) begin
                arready    <= 1'b0;
                busy       <= 1'b1;
                addr       <= araddr;
                beats_left <= arlen;
                ar_wait    <= rnd[1:0];
                r_wait     <= rnd[3:2];
                rnd        <= xorshift(rnd);
            end else if (arvalid && !busy) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            // Data phase, one beat per wait interval
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                if (beats_left == 8'd0) begin
                    busy <= 1'b0;
                end else begin
                    beats_left <= beats_left - 8'd1;
                    addr       <= addr + 32'd4;
                end
            end else if (busy && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= addr ^ DATA_KEY;
                    rresp  <= (addr[31:28] == 4'h0) ? RESP_SLVERR : RESP_OKAY;
                    rlast  <= (beats_left == 8'd0);
                    r_wait <= rnd[5:4];
                    rnd    <= xorshift(rnd);
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

endmodule

// ==== sim/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
    input  logic         clk,
    input  logic         rst,
    input  logic [127:0] test_name,
    input  logic         exu_dnpc_valid,
    input  logic [31:0]  exu_dnpc,
    input  logic         idu_ready,
    input  logic         ifu_valid,
    input  logic [31:0]  ifu_pc,
    input  logic [31:0]  ifu_inst,
    input  logic         access_fault,
    input  logic         arvalid,
    input  logic         arready,
    input  logic [31:0]  araddr,
    input  logic [3:0]   arid,
    input  logic [7:0]   arlen,
    input  logic [2:0]   arsize,
    input  logic [1:0]   arburst,
    output int           accepted,
    output int           mismatches,
    output int           ar_errors,
    output int           refetches,
    output int           protocol_errors
);
    import fetch_pkg::*;

    localparam logic [31:0] DATA_KEY = 32'h5A5A_5A5A;

    logic [31:0]          exp_pc;
    logic                 deferred;
    logic [31:0]          deferred_pc;
    logic [NUM_LINES-1:0] line_valid;
    logic [TAG_W-1:0]     line_tag [NUM_LINES];

    always @(posedge clk or posedge rst) begin : watch_outputs
        logic [31:0] next_pc;
        logic [31:0] exp_inst;
        logic        exp_fault;
        int          bad;
        if (rst) begin
            exp_pc      <= RESET_PC;
            deferred    <= 1'b0;
            deferred_pc <= '0;
            accepted    <= 0;
            mismatches  <= 0;
        end else begin
            next_pc = exp_pc;
            bad = 0;
            if (ifu_valid && idu_ready) begin
                exp_inst = next_pc ^ DATA_KEY;
                exp_fault = (next_pc[31:28] == 4'h0);
                if (ifu_pc !== next_pc) begin
                    $display("mismatch %s pc expected %h actual %h",
                             test_name, next_pc, ifu_pc);
                    bad = bad + 1;
                end
                if (ifu_inst !== exp_inst) begin
                    $display("mismatch %s inst expected %h actual %h",
                             test_name, exp_inst, ifu_inst);
                    bad = bad + 1;
                end
                if (access_fault !== exp_fault) begin
                    $display("mismatch %s access_fault expected %b actual %b",
                             test_name, exp_fault, access_fault);
                    bad = bad + 1;
                end
                accepted <= accepted + 1;
                next_pc = deferred ? deferred_pc : next_pc + 32'd4;
                deferred <= 1'b0;
            end
            // A held instruction still goes out before the new target
            if (exu_dnpc_valid) begin
                if (ifu_valid && !idu_ready) begin
                    deferred    <= 1'b1;
                    deferred_pc <= exu_dnpc;
                end else begin
                    next_pc = exu_dnpc;
                end
            end
            exp_pc <= next_pc;
            mismatches <= mismatches + bad;
        end
    end

    always @(posedge clk or posedge rst) begin : watch_ar
        logic               sdram;
        logic [INDEX_W-1:0] idx;
        logic [7:0]         exp_len;
        int                 perr;
        if (rst) begin
            line_valid      <= '0;
            ar_errors       <= 0;
            refetches       <= 0;
            protocol_errors <= 0;
        end else if (arvalid && arready) begin
            sdram = (araddr[31:28] == SDRAM_LO) || (araddr[31:28] == SDRAM_HI);
            idx = araddr[OFFSET_W +: INDEX_W];
            exp_len = sdram ? 8'd3 : 8'd0;
            perr = 0;
            if (arlen !== exp_len) begin
                $display("mismatch %s arlen expected %0d actual %0d",
                         test_name, exp_len, arlen);
                ar_errors <= ar_errors + 1;
            end
            // Word reads with a single ID
            if (arid !== 4'd0) begin
                $display("mismatch %s arid expected 0 actual %0d", test_name, arid);
                perr = perr + 1;
            end
            if (arsize !== 3'd2) begin
                $display("mismatch %s arsize expected 2 actual %0d", test_name, arsize);
                perr = perr + 1;
            end
            if (sdram && arburst !== 2'b01) begin
                $display("mismatch %s arburst expected 1 actual %0d", test_name, arburst);
                perr = perr + 1;
            end
            if (sdram && araddr[OFFSET_W-1:0] != '0) begin
                $display("burst AR at %h is not aligned to a line", araddr);
                perr = perr + 1;
            end
            // Shadow of the cache tags, filled at the first request of a line
            if (araddr[OFFSET_W-1:0] == '0) begin
                if (line_valid[idx] && line_tag[idx] == araddr[31 -: TAG_W]) begin
                    $display("line %h was fetched again although it is cached", araddr);
                    refetches <= refetches + 1;
                end
                line_valid[idx] <= 1'b1;
                line_tag[idx]   <= araddr[31 -: TAG_W];
            end
            protocol_errors <= protocol_errors + perr;
        end
    end

endmodule

// ==== sim/fetch_sva.sv ====
`timescale 1ns/1ps

module fetch_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   arvalid,
    input logic                   arready,
    input logic [31:0]            araddr,
    input logic [7:0]             arlen,
    input logic                   rready,
    input logic                   idu_ready,
    input logic                   ifu_valid,
    input logic [31:0]            ifu_pc,
    input fetch_pkg::fetch_state_e state
);
    import fetch_pkg::*;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)))
        else $error("AR request changed before arready");

    decode_hold: assert property (@(posedge clk) disable iff (rst)
        (ifu_valid && !idu_ready) |=> (ifu_valid && $stable(ifu_pc)))
        else $error("decode output moved during a stall");

    idle_rready: assert property (@(posedge clk) disable iff (rst)
        !(rready && state == FETCH_IDLE))
        else $error("rready high in FETCH_IDLE");

endmodule

bind ifu fetch_sva fetch_sva_inst (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arlen     (arlen),
    .rready    (rready),
    .idu_ready (idu_ready),
    .ifu_valid (ifu_valid),
    .ifu_pc    (ifu_pc),
    .state     (state)
);

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    typedef struct packed {
        logic [127:0] name;
        logic         redirect;
        logic [31:0]  target;
        logic [15:0]  count;
        logic [7:0]   stall;
    } row_t;

    localparam int NUM_ROWS = 8;

    logic         clk;
    logic         rst;
    logic         exu_dnpc_valid;
    logic [31:0]  exu_dnpc;
    logic         idu_ready;
    logic         ifu_valid;
    logic [31:0]  ifu_pc;
    logic [31:0]  ifu_inst;
    logic         access_fault;
    logic         arvalid;
    logic         arready;
    logic [31:0]  araddr;
    logic [3:0]   arid;
    logic [7:0]   arlen;
    logic [2:0]   arsize;
    logic [1:0]   arburst;
    logic         rvalid;
    logic         rready;
    logic [31:0]  rdata;
    logic [1:0]   rresp;
    logic         rlast;
    logic [3:0]   rid;
    logic [127:0] test_name;

    int   accepted;
    int   mismatches;
    int   ar_errors;
    int   refetches;
    int   protocol_errors;
    int   cycles;
    int   limit;
    int   goal;
    logic timed_out;
    logic [2:0] phase;
    row_t cur;
    row_t rows [NUM_ROWS];

    fetch_top fetch_top_inst (.*);

    axi_mem_model memory (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .arlen(arlen), .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .rlast(rlast), .rid(rid)
    );

    fetch_checker watch (.*);

    function automatic row_t make_row(input logic [127:0] name, input logic redirect,
                                      input logic [31:0] target, input logic [15:0] count,
                                      input logic [7:0] stall);
        row_t r;
        r.name = name;
        r.redirect = redirect;
        r.target = target;
        r.count = count;
        r.stall = stall;
        return r;
    endfunction

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        rst <= 1'b1;
        exu_dnpc_valid <= 1'b0;
        exu_dnpc <= '0;
        idu_ready <= 1'b0;
        timed_out = 1'b0;
        test_name <= "reset";
        // Line indices are picked so the revisit rows still find their lines
        rows[0] = make_row("reset_seq", 1'b0, RESET_PC, 16'd12, 8'hFF);
        rows[1] = make_row("sdram_burst", 1'b1, 32'hA000_0100, 16'd10, 8'hFF);
        rows[2] = make_row("line_cross", 1'b1, 32'h3000_0280, 16'd4, 8'hFF);
        rows[3] = make_row("redirect_refill", 1'b1, 32'h3000_0460, 16'd8, 8'hFF);
        rows[4] = make_row("decode_stall", 1'b1, 32'h3000_05A0, 16'd12, 8'b1001_0110);
        rows[5] = make_row("access_fault", 1'b1, 32'h0000_0040, 16'd6, 8'hFF);
        rows[6] = make_row("revisit_sdram", 1'b1, 32'hA000_0100, 16'd8, 8'hFF);
        rows[7] = make_row("revisit_stall", 1'b1, 32'h0000_0040, 16'd6, 8'b0101_1011);
        limit = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + int'(rows[i].count) * 40;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            cur = rows[r];
            goal = accepted + int'(cur.count);
            @(posedge clk);
            test_name <= cur.name;
            idu_ready <= cur.stall[0];
            if (cur.redirect) begin
                exu_dnpc_valid <= 1'b1;
                exu_dnpc       <= cur.target;
            end
            phase = 3'd1;
            @(posedge clk);
            exu_dnpc_valid <= 1'b0;
            while (accepted < goal && !timed_out) begin
                idu_ready <= cur.stall[phase];
                phase = phase + 3'd1;
                if (cycles >= limit) begin
                    $display("timeout: fetch stalled after %0d cycles", cycles);
                    timed_out = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
        end

        $display("errors: mismatch %0d, ar length %0d, refetch %0d, protocol %0d, timeout %0d",
                 mismatches, ar_errors, refetches, protocol_errors, int'(timed_out));
        if (!timed_out && mismatches == 0 && ar_errors == 0 && refetches == 0
            && protocol_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/fetch_pkg.sv
hw/icache_refill_if.sv
hw/icache.sv
hw/ifu.sv
hw/fetch_top.sv
sim/axi_mem_model.sv
sim/fetch_checker.sv
sim/fetch_sva.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f sources.f \
    -Mdir obj_dir -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -qx "test passed" sim.log && echo "PASS" && exit 0 || echo "FAIL"
exit 1
